//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f flist.f --top-module int_core_tb -Mdir obj_dir
	./obj_dir/Vint_core_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- flist.f
logic/core_pkg.sv
logic/reg_port_if.sv
logic/inst_decoder.sv
logic/skid_buffer.sv
logic/alu_execute.sv
logic/reg_commit.sv
logic/int_core.sv
tests/tb_clock.sv
tests/int_core_tb.sv

//--- logic/alu_execute.sv
////////////////////
// integer alu, one request per cycle
////////////////////
module alu_execute (
    input  logic                req_valid,
    output logic                req_ready,
    input  core_pkg::exec_req_t req,
    output logic                wb_valid,
    input  logic                wb_ready,
    output core_pkg::wb_t       wb
);

    logic [core_pkg::xlen-1:0]    result;
    logic [core_pkg::shamt_w-1:0] sh;

    assign sh = req.b[core_pkg::shamt_w-1:0];

    always_comb begin
        case (req.alu_op)
            core_pkg::alu_add:    result = req.a + req.b;
            core_pkg::alu_sub:    result = req.a - req.b;
            core_pkg::alu_sll:    result = req.a << sh;
            core_pkg::alu_slt:
                result = core_pkg::xlen'($signed(req.a) < $signed(req.b));
            core_pkg::alu_sltu:   result = core_pkg::xlen'(req.a < req.b);
            core_pkg::alu_xor:    result = req.a ^ req.b;
            core_pkg::alu_srl:    result = req.a >> sh;
            core_pkg::alu_sra:    result = $unsigned($signed(req.a) >>> sh);
            core_pkg::alu_or:     result = req.a | req.b;
            core_pkg::alu_and:    result = req.a & req.b;
            // lui
            core_pkg::alu_pass_b: result = req.b;
            default:              result = '0;
        endcase
    end

    // pure combinational stage, handshake passes straight through
    assign wb_valid   = req_valid;
    assign req_ready  = wb_ready;

    assign wb.rd      = req.rd;
    assign wb.illegal = req.illegal;
    assign wb.value   = req.illegal ? '0 : result;

endmodule

//--- logic/core_pkg.sv
////////////////////
// widths, opcodes, funct3 codes, alu operations
// and the payload structs passed between stages
////////////////////
package core_pkg;

    localparam int xlen    = 32;
    localparam int reg_aw  = 5;
    localparam int reg_num = 32;
    localparam int shamt_w = 5;
    // at most four claims can be in flight in the two skid buffers
    localparam int busy_cw = 3;

    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_e;

    typedef struct packed {
        alu_op_e             alu_op;
        logic [reg_aw-1:0]   rd;
        logic [xlen-1:0]     a;
        logic [xlen-1:0]     b;
        logic                illegal;
    } exec_req_t;

    typedef struct packed {
        logic [reg_aw-1:0]   rd;
        logic [xlen-1:0]     value;
        logic                illegal;
    } wb_t;

endpackage

//--- logic/inst_decoder.sv
////////////////////
// instruction decoder with operand read,
// source stall and destination claim
////////////////////
module inst_decoder (
    input  logic                clk_in,
    input  logic                rst_n,
    input  logic                inst_valid,
    output logic                inst_ready,
    input  logic [31:0]         inst,
    reg_port_if.decoder         rf_port,
    output logic                req_valid,
    input  logic                req_ready,
    output core_pkg::exec_req_t req
);

    logic [6:0]                  opcode;
    logic [2:0]                  funct3;
    logic [core_pkg::reg_aw-1:0] rd;
    logic [core_pkg::xlen-1:0]   imm_i;
    logic [core_pkg::xlen-1:0]   imm_u;
    logic [core_pkg::xlen-1:0]   shamt;
    logic                        use_rs1;
    logic                        use_rs2;
    logic                        stall;

    // bit 30 tells sub from add and sra from srl
    function automatic core_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt,
                                                  input logic is_reg);
        case (f3)
            core_pkg::f3_add_sub: alu_sel = (alt && is_reg) ? core_pkg::alu_sub : core_pkg::alu_add;
            core_pkg::f3_sll:     alu_sel = core_pkg::alu_sll;
            core_pkg::f3_slt:     alu_sel = core_pkg::alu_slt;
            core_pkg::f3_sltu:    alu_sel = core_pkg::alu_sltu;
            core_pkg::f3_xor:     alu_sel = core_pkg::alu_xor;
            core_pkg::f3_srl_sra: alu_sel = alt ? core_pkg::alu_sra : core_pkg::alu_srl;
            core_pkg::f3_or:      alu_sel = core_pkg::alu_or;
            default:              alu_sel = core_pkg::alu_and;
        endcase
    endfunction

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign rd     = inst[11:7];
    assign imm_i  = {{(core_pkg::xlen-12){inst[31]}}, inst[31:20]};
    assign imm_u  = {inst[31:12], 12'b0};
    assign shamt  = {{(core_pkg::xlen-core_pkg::shamt_w){1'b0}}, inst[24:20]};

    assign rf_port.rs1      = inst[19:15];
    assign rf_port.rs2      = inst[24:20];
    assign rf_port.claim_rd = rd;

    always_comb begin
        req         = '0;
        req.rd      = rd;
        req.alu_op  = alu_sel(funct3, inst[30], opcode == core_pkg::opc_op);
        use_rs1     = 1'b0;
        use_rs2     = 1'b0;
        case (opcode)
            core_pkg::opc_op: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                req.a   = rf_port.rs1_data;
                req.b   = rf_port.rs2_data;
            end
            core_pkg::opc_op_imm: begin
                use_rs1 = 1'b1;
                req.a   = rf_port.rs1_data;
                // shifts take the shamt field instead of the I immediate
                req.b   = (funct3 == core_pkg::f3_sll || funct3 == core_pkg::f3_srl_sra) ?
                          shamt : imm_i;
            end
            core_pkg::opc_lui: begin
                req.alu_op = core_pkg::alu_pass_b;
                req.b      = imm_u;
            end
            default: begin
                req.alu_op  = core_pkg::alu_add;
                req.illegal = 1'b1;
            end
        endcase
    end

    // sources at x0 never stall
    assign stall = (use_rs1 && rf_port.rs1 != '0 && rf_port.rs1_busy) ||
                   (use_rs2 && rf_port.rs2 != '0 && rf_port.rs2_busy);

    assign inst_ready       = req_ready && !stall;
    assign req_valid        = inst_valid && !stall;
    assign rf_port.claim_en = inst_valid && inst_ready && !req.illegal && rd != '0;

    // a stalled instruction stays on the port until accepted
    a_inst_held: assert property (@(posedge clk_in) disable iff (!rst_n)
        inst_valid && !inst_ready |=> inst_valid && $stable(inst));

endmodule

//--- logic/int_core.sv
////////////////////
// integer slice top level
////////////////////
module int_core (
    input  logic        clk_in,
    input  logic        rst_n,
    input  logic        inst_valid,
    output logic        inst_ready,
    input  logic [31:0] inst,
    output logic        commit_valid,
    input  logic        commit_ready,
    output logic [4:0]  commit_rd,
    output logic [31:0] commit_data,
    output logic        commit_illegal
);

    // decode to req_buf_i
    logic                dec_valid;
    logic                dec_ready;
    core_pkg::exec_req_t dec_req;

    // req_buf_i to alu
    logic                exe_valid;
    logic                exe_ready;
    core_pkg::exec_req_t exe_req;

    // alu to wb_buf_i
    logic                alu_valid;
    logic                alu_ready;
    core_pkg::wb_t       alu_wb;

    // wb_buf_i to regfile
    logic                wb_valid;
    logic                wb_ready;
    core_pkg::wb_t       wb;

    reg_port_if rf_if ();

    inst_decoder decoder_i (
        .clk_in     (clk_in),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst       (inst),
        .rf_port    (rf_if.decoder),
        .req_valid  (dec_valid),
        .req_ready  (dec_ready),
        .req        (dec_req)
    );

    skid_buffer #(.payload_t(core_pkg::exec_req_t)) req_buf_i (
        .clk_in    (clk_in),
        .rst_n     (rst_n),
        .in_valid  (dec_valid),
        .in_ready  (dec_ready),
        .in_data   (dec_req),
        .out_valid (exe_valid),
        .out_ready (exe_ready),
        .out_data  (exe_req)
    );

    alu_execute alu_i (
        .req_valid (exe_valid),
        .req_ready (exe_ready),
        .req       (exe_req),
        .wb_valid  (alu_valid),
        .wb_ready  (alu_ready),
        .wb        (alu_wb)
    );

    skid_buffer #(.payload_t(core_pkg::wb_t)) wb_buf_i (
        .clk_in    (clk_in),
        .rst_n     (rst_n),
        .in_valid  (alu_valid),
        .in_ready  (alu_ready),
        .in_data   (alu_wb),
        .out_valid (wb_valid),
        .out_ready (wb_ready),
        .out_data  (wb)
    );

    reg_commit commit_i (
        .clk_in         (clk_in),
        .rst_n          (rst_n),
        .rf_port        (rf_if.regfile),
        .wb_valid       (wb_valid),
        .wb_ready       (wb_ready),
        .wb             (wb),
        .commit_valid   (commit_valid),
        .commit_ready   (commit_ready),
        .commit_rd      (commit_rd),
        .commit_data    (commit_data),
        .commit_illegal (commit_illegal)
    );

endmodule

//--- logic/reg_commit.sv
////////////////////
// register file with busy counts, writeback
// and the commit output register
////////////////////
module reg_commit (
    input  logic                        clk_in,
    input  logic                        rst_n,
    reg_port_if.regfile                 rf_port,
    input  logic                        wb_valid,
    output logic                        wb_ready,
    input  core_pkg::wb_t               wb,
    output logic                        commit_valid,
    input  logic                        commit_ready,
    output logic [core_pkg::reg_aw-1:0] commit_rd,
    output logic [core_pkg::xlen-1:0]   commit_data,
    output logic                        commit_illegal
);

    // x0 has no storage
    logic [core_pkg::xlen-1:0]    regs     [1:core_pkg::reg_num-1];
    logic [core_pkg::busy_cw-1:0] busy_cnt [1:core_pkg::reg_num-1];
    logic                         wb_fire;
    logic                         wr_en;

    assign wb_ready = !commit_valid || commit_ready;
    assign wb_fire  = wb_valid && wb_ready;
    assign wr_en    = wb_fire && !wb.illegal && wb.rd != '0;

    // bypass the value written this cycle
    function automatic logic [core_pkg::xlen-1:0] read_data(
        input logic [core_pkg::reg_aw-1:0] idx);
        if (idx == '0) begin
            return '0;
        end
        if (wr_en && wb.rd == idx) begin
            return wb.value;
        end
        return regs[idx];
    endfunction

    // the last pending write releasing now counts as not busy
    function automatic logic read_busy(input logic [core_pkg::reg_aw-1:0] idx);
        if (idx == '0) begin
            return 1'b0;
        end
        if (wr_en && wb.rd == idx && busy_cnt[idx] == core_pkg::busy_cw'(1)) begin
            return 1'b0;
        end
        return busy_cnt[idx] != '0;
    endfunction

    always_comb begin
        rf_port.rs1_data = read_data(rf_port.rs1);
        rf_port.rs2_data = read_data(rf_port.rs2);
        rf_port.rs1_busy = read_busy(rf_port.rs1);
        rf_port.rs2_busy = read_busy(rf_port.rs2);
    end

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < core_pkg::reg_num; i++) begin
                regs[i]     <= '0;
                busy_cnt[i] <= '0;
            end
        end else begin
            for (int i = 1; i < core_pkg::reg_num; i++) begin
                // claim and release of the same register cancel out
                if (rf_port.claim_en && rf_port.claim_rd == core_pkg::reg_aw'(i)) begin
                    if (!(wr_en && wb.rd == core_pkg::reg_aw'(i))) begin
                        busy_cnt[i] <= busy_cnt[i] + 1'b1;
                    end
                end else if (wr_en && wb.rd == core_pkg::reg_aw'(i)) begin
                    busy_cnt[i] <= busy_cnt[i] - 1'b1;
                end
            end
            if (wr_en) begin
                regs[wb.rd] <= wb.value;
            end
        end
    end

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            commit_valid <= 1'b0;
        end else if (wb_fire) begin
            commit_valid <= 1'b1;
        end else if (commit_ready) begin
            commit_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_in) begin
        if (wb_fire) begin
            commit_rd      <= wb.rd;
            commit_data    <= wb.value;
            commit_illegal <= wb.illegal;
        end
    end

    // the decoder claimed this register before it reached writeback
    a_busy_on_wb: assert property (@(posedge clk_in) disable iff (!rst_n)
        wr_en |-> busy_cnt[wb.rd] != '0);

endmodule

//--- logic/reg_port_if.sv
////////////////////
// register read, busy status and claim port
////////////////////
interface reg_port_if;

    // read indices from the decoder
    logic [core_pkg::reg_aw-1:0] rs1;
    logic [core_pkg::reg_aw-1:0] rs2;

    // operand values, already bypassed
    logic [core_pkg::xlen-1:0]   rs1_data;
    logic [core_pkg::xlen-1:0]   rs2_data;
    logic                        rs1_busy;
    logic                        rs2_busy;

    // destination claim, one pulse per accepted instruction
    logic                        claim_en;
    logic [core_pkg::reg_aw-1:0] claim_rd;

    modport decoder (
        output rs1, rs2, claim_en, claim_rd,
        input  rs1_data, rs2_data, rs1_busy, rs2_busy
    );

    modport regfile (
        input  rs1, rs2, claim_en, claim_rd,
        output rs1_data, rs2_data, rs1_busy, rs2_busy
    );

endinterface

//--- logic/skid_buffer.sv
////////////////////
// two-entry valid/ready buffer, any payload
////////////////////
module skid_buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk_in,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     skid_valid;
    payload_t skid_data;
    logic     out_free;

    // output register can take a new item this cycle
    assign out_free = out_ready || !out_valid;

    // registered, so no path from out_ready
    assign in_ready = !skid_valid;

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_free) begin
            if (skid_valid) begin
                out_valid  <= 1'b1;
                skid_valid <= 1'b0;
            end else begin
                out_valid <= in_valid;
            end
        end else if (in_valid && in_ready) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (out_free) begin
            out_data <= skid_valid ? skid_data : in_data;
        end
        // park the incoming item while the output stalls
        if (!out_free && in_ready) begin
            skid_data <= in_data;
        end
    end

    a_out_stable: assert property (@(posedge clk_in) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

//--- tests/int_core_tb.sv
////////////////////
// table-driven testbench for int_core
// with random gaps and commit back-pressure
////////////////////
module int_core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int n_entries = 33;

    typedef struct packed {
        logic [31:0] word;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        illegal;
    } entry_t;

    logic        clk_in;
    logic        rst_n;
    logic        inst_valid;
    logic        inst_ready;
    logic [31:0] inst;
    logic        commit_valid;
    logic        commit_ready;
    logic [4:0]  commit_rd;
    logic [31:0] commit_data;
    logic        commit_illegal;

    entry_t vectors [n_entries];
    int     n_filled     = 0;
    int     n_commits    = 0;
    int     value_errors = 0;
    int     other_errors = 0;
    integer seed;

    tb_clock clock_i (
        .clk_in (clk_in),
        .rst_n  (rst_n)
    );

    int_core dut_i (
        .clk_in         (clk_in),
        .rst_n          (rst_n),
        .inst_valid     (inst_valid),
        .inst_ready     (inst_ready),
        .inst           (inst),
        .commit_valid   (commit_valid),
        .commit_ready   (commit_ready),
        .commit_rd      (commit_rd),
        .commit_data    (commit_data),
        .commit_illegal (commit_illegal)
    );

    function automatic logic [31:0] imm_word(input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, core_pkg::opc_op_imm};
    endfunction

    // alt selects sub and sra
    function automatic logic [31:0] reg_word(input logic [2:0] f3, input logic alt,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, core_pkg::opc_op};
    endfunction

    function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, core_pkg::opc_lui};
    endfunction

    task automatic add_entry(input logic [31:0] word, input logic [4:0] rd,
                             input logic [31:0] data, input logic illegal);
        vectors[n_filled] = '{word, rd, data, illegal};
        n_filled++;
    endtask

    task automatic fill_table();
        // x1 = -5, x2..x7 and x26, x27 from immediates
        add_entry(imm_word(core_pkg::f3_add_sub, 1, 0, 12'hffb), 1, 32'hffff_fffb, 0);
        add_entry(lui_word(2, 20'h12345), 2, 32'h1234_5000, 0);
        add_entry(imm_word(core_pkg::f3_xor, 3, 2, 12'h0ff), 3, 32'h1234_50ff, 0);
        add_entry(imm_word(core_pkg::f3_or, 4, 0, 12'h7f0), 4, 32'h0000_07f0, 0);
        add_entry(imm_word(core_pkg::f3_and, 5, 3, 12'h0f0), 5, 32'h0000_00f0, 0);
        add_entry(imm_word(core_pkg::f3_slt, 6, 1, 12'h000), 6, 32'h1, 0);
        add_entry(imm_word(core_pkg::f3_sltu, 7, 1, 12'h005), 7, 32'h0, 0);
        add_entry(imm_word(core_pkg::f3_sltu, 26, 4, 12'hfff), 26, 32'h1, 0);
        add_entry(imm_word(core_pkg::f3_slt, 27, 4, 12'hfff), 27, 32'h0, 0);
        // register ops on the values above
        add_entry(reg_word(core_pkg::f3_add_sub, 0, 8, 2, 4), 8, 32'h1234_57f0, 0);
        add_entry(reg_word(core_pkg::f3_add_sub, 1, 9, 4, 2), 9, 32'hedcb_b7f0, 0);
        add_entry(reg_word(core_pkg::f3_and, 0, 10, 3, 1), 10, 32'h1234_50fb, 0);
        add_entry(reg_word(core_pkg::f3_or, 0, 11, 4, 5), 11, 32'h0000_07f0, 0);
        add_entry(reg_word(core_pkg::f3_xor, 0, 12, 2, 3), 12, 32'h0000_00ff, 0);
        add_entry(reg_word(core_pkg::f3_slt, 0, 13, 1, 4), 13, 32'h1, 0);
        add_entry(reg_word(core_pkg::f3_sltu, 0, 14, 1, 4), 14, 32'h0, 0);
        add_entry(reg_word(core_pkg::f3_sll, 0, 15, 2, 6), 15, 32'h2468_a000, 0);
        add_entry(reg_word(core_pkg::f3_srl_sra, 0, 16, 1, 6), 16, 32'h7fff_fffd, 0);
        add_entry(reg_word(core_pkg::f3_srl_sra, 1, 17, 1, 6), 17, 32'hffff_fffd, 0);
        add_entry(imm_word(core_pkg::f3_sll, 18, 2, 12'h004), 18, 32'h2345_0000, 0);
        add_entry(imm_word(core_pkg::f3_srl_sra, 19, 1, 12'h01c), 19, 32'h0000_000f, 0);
        add_entry(imm_word(core_pkg::f3_srl_sra, 20, 1, 12'h41f), 20, 32'hffff_ffff, 0);
        // dependent chain through x21 and x22
        add_entry(imm_word(core_pkg::f3_add_sub, 21, 0, 12'h001), 21, 32'h1, 0);
        add_entry(reg_word(core_pkg::f3_add_sub, 0, 21, 21, 21), 21, 32'h2, 0);
        add_entry(reg_word(core_pkg::f3_add_sub, 0, 21, 21, 21), 21, 32'h4, 0);
        add_entry(imm_word(core_pkg::f3_add_sub, 21, 21, 12'h003), 21, 32'h7, 0);
        add_entry(imm_word(core_pkg::f3_sll, 21, 21, 12'h002), 21, 32'h1c, 0);
        add_entry(reg_word(core_pkg::f3_add_sub, 1, 22, 21, 1), 22, 32'h21, 0);
        add_entry(reg_word(core_pkg::f3_xor, 0, 22, 22, 21), 22, 32'h3d, 0);
        // x0 keeps zero, the commit still shows the sum
        add_entry(imm_word(core_pkg::f3_add_sub, 0, 1, 12'h064), 0, 32'h5f, 0);
        add_entry(reg_word(core_pkg::f3_add_sub, 0, 23, 0, 4), 23, 32'h0000_07f0, 0);
        // load word, not supported, x21 must stay 0x1c
        add_entry({12'h000, 5'd0, 3'b010, 5'd21, 7'b0000011}, 21, 32'h0, 1);
        add_entry(imm_word(core_pkg::f3_add_sub, 24, 21, 12'h000), 24, 32'h1c, 0);
    endtask

    task automatic check_commit(input entry_t exp);
        rd_check: assert (commit_rd == exp.rd) else begin
            $display("** Error: commit_rd is %h, expected %h at commit %0d",
                     commit_rd, exp.rd, n_commits);
            value_errors++;
        end
        data_check: assert (commit_data == exp.data) else begin
            $display("** Error: commit_data is %h, expected %h at commit %0d",
                     commit_data, exp.data, n_commits);
            value_errors++;
        end
        illegal_check: assert (commit_illegal == exp.illegal) else begin
            $display("** Error: commit_illegal is %h, expected %h at commit %0d",
                     commit_illegal, exp.illegal, n_commits);
            value_errors++;
        end
    endtask

    task automatic finish_run();
        $display("value errors: %0d, other errors: %0d, commits: %0d of %0d",
                 value_errors, other_errors, n_commits, n_entries);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    // one commit per edge where valid and ready are both high
    always @(posedge clk_in) begin
        if (rst_n && commit_valid && commit_ready) begin
            if (n_commits < n_entries) begin
                check_commit(vectors[n_commits]);
            end else begin
                $display("an extra commit arrived after the last table entry");
                other_errors++;
            end
            n_commits++;
        end
    end

    initial begin
        int n_sent;

        n_sent       = 0;
        inst_valid   = 1'b0;
        inst         = '0;
        commit_ready = 1'b0;
        seed         = 49210;
        fill_table();
        wait (rst_n);
        while (n_sent < n_entries) begin
            @(posedge clk_in);
            if (inst_valid && inst_ready) begin
                n_sent++;
            end
            commit_ready <= (($random(seed) & 3) != 0);
            if (inst_valid && !inst_ready) begin
                // stalled item stays on the port
                inst_valid <= 1'b1;
            end else if (n_sent < n_entries && (($random(seed) & 3) != 0)) begin
                inst_valid <= 1'b1;
                inst       <= vectors[n_sent].word;
            end else begin
                inst_valid <= 1'b0;
            end
        end
        while (n_commits < n_entries) begin
            @(posedge clk_in);
            commit_ready <= (($random(seed) & 3) != 0);
        end
        commit_ready <= 1'b1;
        repeat (6) @(posedge clk_in);
        count_check: assert (n_commits == n_entries) else begin
            $display("commit count %0d differs from the table length %0d",
                     n_commits, n_entries);
            other_errors++;
        end
        finish_run();
    end

    // 30 cycles of 4 ns per table entry
    initial begin
        #(n_entries * 30 * 4);
        $display("watchdog expired, commits stopped after %0d of %0d", n_commits, n_entries);
        other_errors++;
        finish_run();
    end

endmodule

//--- tests/tb_clock.sv
////////////////////
// testbench clock and reset
////////////////////
module tb_clock (
    output logic clk_in,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    // 4 ns period
    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    // reset held over the first 3 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk_in);
        rst_n <= 1'b1;
    end

endmodule
